// ==== Bender.yml ====
package:
  name: kv_store

sources:
  - files:
      - kv_store_pkg.sv
      - kv_mem_if.sv
      - kv_store_array.sv
      - kv_ctrl_engine.sv
      - kv_store_top.sv
  - target: test
    files:
      - tb_kv_store.sv

# Testbench top module is tb_kv_store
# RTL top level is kv_store_top

// ==== kv_ctrl_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module kv_ctrl_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  kv_store_pkg::cmd_t   cmd,
    input  kv_store_pkg::key_t   key,
    input  kv_store_pkg::value_t value_in,
    output logic                 rdy,
    output logic                 ack,
    output logic                 error,
    output logic                 found,
    output kv_store_pkg::value_t value_out,
    output logic                 init,
    input  logic                 init_done,
    kv_mem_if.engine             mem
);
    import kv_store_pkg::*;

    // ========================================================================
    // Declarations
    // ========================================================================
    state_t state_q;

    // Command latched at accept
    cmd_t   cmd_q;
    key_t   key_q;
    value_t val_q;

    // Entry as it was before the command
    entry_t old_q;

    // Sweep control
    logic   kick_q;
    logic   clr_q;
    logic   init_q;

    // Response registers
    logic   ack_q;
    logic   error_q;
    logic   found_q;
    value_t value_out_q;

    logic   accept;
    logic   do_write;
    entry_t new_entry;

    // Commands that touch one entry
    function automatic logic is_data_cmd(input cmd_t c);
        return c inside {cmd_get, cmd_set, cmd_unset, cmd_replace};
    endfunction

    // ========================================================================
    // Handshake and read issue
    // ========================================================================
    assign rdy    = (state_q == st_idle) && init_done;
    assign accept = req && rdy;

    // Read goes out on the accept edge itself
    assign mem.rd_en  = accept && is_data_cmd(cmd);
    assign mem.rd_key = key;

    // ========================================================================
    // Write decision from the old entry
    // ========================================================================
    always_comb begin
        new_entry = '0;
        do_write  = 1'b0;
        case (cmd_q)
            cmd_set: begin
                new_entry.valid = 1'b1;
                new_entry.value = val_q;
                do_write        = 1'b1;
            end
            cmd_replace: begin
                new_entry.valid = 1'b1;
                new_entry.value = val_q;
                do_write        = old_q.valid;
            end
            // Leaves an empty, zeroed slot
            cmd_unset: begin
                do_write = 1'b1;
            end
            default: begin
                do_write = 1'b0;
            end
        endcase
    end

    assign mem.wr_en    = (state_q == st_write) && do_write;
    assign mem.wr_key   = key_q;
    assign mem.wr_entry = new_entry;

    // ========================================================================
    // Payload capture
    // ========================================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
            key_q <= key;
            val_q <= value_in;
        end
        if (state_q == st_read) begin
            old_q <= mem.rd_entry;
        end
    end

    // ========================================================================
    // FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= st_sweep;
            kick_q      <= 1'b1;
            clr_q       <= 1'b0;
            init_q      <= 1'b0;
            ack_q       <= 1'b0;
            error_q     <= 1'b0;
            found_q     <= 1'b0;
            value_out_q <= '0;
        end else begin
            // Pulses and response fields default low
            init_q      <= 1'b0;
            ack_q       <= 1'b0;
            error_q     <= 1'b0;
            found_q     <= 1'b0;
            value_out_q <= '0;
            case (state_q)
                st_sweep: begin
                    if (kick_q) begin
                        init_q <= 1'b1;
                        kick_q <= 1'b0;
                    end else if (!init_q && init_done) begin
                        state_q <= st_idle;
                        // Only a clear command is acknowledged here
                        ack_q   <= clr_q;
                        clr_q   <= 1'b0;
                    end
                end
                st_idle: begin
                    if (accept) begin
                        if (cmd == cmd_clear) begin
                            state_q <= st_sweep;
                            kick_q  <= 1'b1;
                            clr_q   <= 1'b1;
                        end else if (is_data_cmd(cmd)) begin
                            state_q <= st_read;
                        end else begin
                            state_q <= st_respond;
                        end
                    end
                end
                st_read: begin
                    state_q <= (cmd_q == cmd_get) ? st_respond : st_write;
                end
                st_write: begin
                    state_q <= st_respond;
                end
                st_respond: begin
                    state_q <= st_idle;
                    ack_q   <= 1'b1;
                    if (is_data_cmd(cmd_q)) begin
                        found_q     <= old_q.valid;
                        value_out_q <= old_q.valid ? old_q.value : '0;
                    end else begin
                        error_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    assign init      = init_q;
    assign ack       = ack_q;
    assign error     = error_q;
    assign found     = found_q;
    assign value_out = value_out_q;

endmodule : kv_ctrl_engine

`default_nettype wire

// ==== kv_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface kv_mem_if;
    import kv_store_pkg::*;

    // Read port, data comes back one cycle after rd_en
    logic   rd_en;
    key_t   rd_key;
    entry_t rd_entry;

    // Write port, takes effect on the edge with wr_en high
    logic   wr_en;
    key_t   wr_key;
    entry_t wr_entry;

    // Control unit side
    modport engine (
        output rd_en,
        output rd_key,
        input  rd_entry,
        output wr_en,
        output wr_key,
        output wr_entry
    );

    // Storage side
    modport store (
        input  rd_en,
        input  rd_key,
        output rd_entry,
        input  wr_en,
        input  wr_key,
        input  wr_entry
    );

endinterface : kv_mem_if

`default_nettype wire

// ==== kv_store.f ====
kv_store_pkg.sv
kv_mem_if.sv
kv_store_array.sv
kv_ctrl_engine.sv
kv_store_top.sv
tb_kv_store.sv

// ==== kv_store_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module kv_store_array (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    init,
    output logic    init_done,
    kv_mem_if.store mem
);
    import kv_store_pkg::*;

    // ========================================================================
    // Storage and sweep state
    // ========================================================================
    entry_t store_q [num_entries];

    logic   sweep_q;
    logic   done_q;
    key_t   sweep_addr_q;

    // Port accesses are only honoured outside a sweep
    logic   port_en;

    // Write mux between the sweep and the port
    logic   we;
    key_t   waddr;
    entry_t wdata;

    assign port_en = !sweep_q && !init;

    // ========================================================================
    // Clear sweep
    // ========================================================================
    // An init pulse restarts the walk from address zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_q      <= 1'b0;
            done_q       <= 1'b0;
            sweep_addr_q <= '0;
        end else if (init) begin
            sweep_q      <= 1'b1;
            done_q       <= 1'b0;
            sweep_addr_q <= '0;
        end else if (sweep_q) begin
            sweep_addr_q <= sweep_addr_q + 1'b1;
            // Last address written this cycle
            if (sweep_addr_q == key_t'(num_entries - 1)) begin
                sweep_q <= 1'b0;
                done_q  <= 1'b1;
            end
        end
    end

    // Drops in the same cycle as init
    assign init_done = done_q && !init;

    // ========================================================================
    // Write path
    // ========================================================================
    always_comb begin
        if (sweep_q) begin
            we    = 1'b1;
            waddr = sweep_addr_q;
            wdata = '0;
        end else begin
            we    = mem.wr_en && port_en;
            waddr = mem.wr_key;
            wdata = mem.wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            store_q[waddr] <= wdata;
        end
    end

    // ========================================================================
    // Read path
    // ========================================================================
    // Registered read, the output holds until the next accepted read
    always_ff @(posedge clk) begin
        if (mem.rd_en && port_en) begin
            mem.rd_entry <= store_q[mem.rd_key];
        end
    end

endmodule : kv_store_array

`default_nettype wire

// ==== kv_store_pkg.sv ====
`default_nettype none

package kv_store_pkg;

    // ========================================================================
    // Sizes
    // ========================================================================
    localparam int key_w       = 12;
    localparam int value_w     = 32;
    localparam int num_entries = 2 ** key_w;

    typedef logic [key_w-1:0]   key_t;
    typedef logic [value_w-1:0] value_t;

    // ========================================================================
    // Commands and engine states
    // ========================================================================
    // Codes 5 to 7 are not assigned and get an error ack
    typedef enum logic [2:0] {
        cmd_get     = 3'd0,
        cmd_set     = 3'd1,
        cmd_unset   = 3'd2,
        cmd_replace = 3'd3,
        cmd_clear   = 3'd4
    } cmd_t;

    typedef enum logic [2:0] {
        st_sweep   = 3'd0,
        st_idle    = 3'd1,
        st_read    = 3'd2,
        st_write   = 3'd3,
        st_respond = 3'd4
    } state_t;

    // ========================================================================
    // Stored word
    // ========================================================================
    // An empty slot is valid low with a zero value
    typedef struct packed {
        logic   valid;
        value_t value;
    } entry_t;

endpackage : kv_store_pkg

`default_nettype wire

// ==== kv_store_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kv_store_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Command side
    input  logic                 req,
    input  kv_store_pkg::cmd_t   cmd,
    input  kv_store_pkg::key_t   key,
    input  kv_store_pkg::value_t value_in,
    output logic                 rdy,

    // Response side, valid with ack only
    output logic                 ack,
    output logic                 error,
    output logic                 found,
    output kv_store_pkg::value_t value_out
);

    // ========================================================================
    // Internal connections
    // ========================================================================
    logic init;
    logic init_done;

    kv_mem_if i_kv_mem_if ();

    // ========================================================================
    // Control unit
    // ========================================================================
    kv_ctrl_engine i_kv_ctrl_engine (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .req       ( req ),
        .cmd       ( cmd ),
        .key       ( key ),
        .value_in  ( value_in ),
        .rdy       ( rdy ),
        .ack       ( ack ),
        .error     ( error ),
        .found     ( found ),
        .value_out ( value_out ),
        .init      ( init ),
        .init_done ( init_done ),
        .mem       ( i_kv_mem_if.engine )
    );

    // ========================================================================
    // Entry storage
    // ========================================================================
    kv_store_array i_kv_store_array (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .init      ( init ),
        .init_done ( init_done ),
        .mem       ( i_kv_mem_if.store )
    );

endmodule : kv_store_top

`default_nettype wire

// ==== tb_kv_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kv_store;
    import kv_store_pkg::*;

    // Reset sweep, one clear, one spare sweep, then a budget per command
    localparam int max_cmds    = 64;
    localparam int cycle_limit = 3 * num_entries + 64 * max_cmds + 512;

    logic   clk;
    logic   rst_n;
    logic   req;
    cmd_t   cmd;
    key_t   key;
    value_t value_in;
    logic   rdy;
    logic   ack;
    logic   error;
    logic   found;
    value_t value_out;

    logic [31:0] seed;
    int          cycles;
    int          ack_count;
    int          cmds_issued;
    key_t        key_pool [8];

    // Expected contents, a missing key is an empty slot
    entry_t      model [key_t];

    kv_store_top dut (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .req       ( req ),
        .cmd       ( cmd ),
        .key       ( key ),
        .value_in  ( value_in ),
        .rdy       ( rdy ),
        .ack       ( ack ),
        .error     ( error ),
        .found     ( found ),
        .value_out ( value_out )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Checks
    // ========================================================================
    task automatic report_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_entry(input entry_t exp);
        if (found !== exp.valid || value_out !== exp.value) begin
            $display("Error: found got %h expected %h", found, exp.valid);
            $display("Error: value_out got %h expected %h", value_out, exp.value);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            report_failure();
        end
    end

    // Ack counting, response fields must stay zero between acks
    always @(negedge clk) begin
        if (ack) begin
            ack_count <= ack_count + 1;
        end else if (rst_n) begin
            check_bit("error", error, 1'b0);
            check_entry('0);
        end
    end

    // ========================================================================
    // Stimulus helpers and reference model
    // ========================================================================
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic key_t rand_key();
        logic [31:0] r;
        r = lcg_next();
        return r[27:16];
    endfunction

    // A key that the model holds as empty
    function automatic key_t fresh_key();
        key_t k;
        k = rand_key();
        while (model.exists(k) && model[k].valid) begin
            k = rand_key();
        end
        return k;
    endfunction

    function automatic entry_t make_entry(input value_t v);
        entry_t e;
        e.valid = 1'b1;
        e.value = v;
        return e;
    endfunction

    task automatic model_apply(input cmd_t c, input key_t k, input value_t v,
                               output entry_t old, output logic err);
        old = model.exists(k) ? model[k] : '0;
        err = 1'b0;
        case (c)
            cmd_get:     ;
            cmd_set:     model[k] = make_entry(v);
            cmd_unset:   model[k] = '0;
            cmd_replace: begin
                if (old.valid) begin
                    model[k] = make_entry(v);
                end
            end
            cmd_clear: begin
                model.delete();
                old = '0;
            end
            default: begin
                err = 1'b1;
                old = '0;
            end
        endcase
    endtask

    // Called on a rising edge
    task automatic drive_cmd(input cmd_t c, input key_t k, input value_t v);
        req      <= 1'b1;
        cmd      <= c;
        key      <= k;
        value_in <= v;
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!rdy) @(negedge clk);
    endtask

    // Called on a falling edge, returns right after the accept edge
    task automatic wait_accept();
        while (!rdy) @(negedge clk);
        @(posedge clk);
        cmds_issued++;
    endtask

    // The DUT stays busy until its ack
    task automatic wait_ack();
        @(negedge clk);
        while (!ack) begin
            check_bit("rdy", rdy, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic run_cmd(input cmd_t c, input key_t k, input value_t v,
                           input entry_t exp, input logic exp_err);
        entry_t old;
        logic   err;
        @(posedge clk);
        drive_cmd(c, k, v);
        @(negedge clk);
        wait_accept();
        req <= 1'b0;
        model_apply(c, k, v, old, err);
        wait_ack();
        check_entry(exp);
        check_bit("error", error, exp_err);
    endtask

    task automatic pick_random(output cmd_t c, output key_t k, output value_t v);
        logic [31:0] r;
        r = lcg_next();
        case (int'(r[23:16]) % 5)
            0:       c = cmd_get;
            1:       c = cmd_set;
            2:       c = cmd_unset;
            3:       c = cmd_replace;
            default: c = cmd_t'(3'd5 + 3'(int'(r[9:8]) % 3));
        endcase
        k = key_pool[r[26:24]];
        v = lcg_next();
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic test_reset_state();
        wait_ready();
        check_bit("ack", ack, 1'b0);
        check_count("ack count", ack_count, 0);
        run_cmd(cmd_get, rand_key(), '0, '0, 1'b0);
    endtask

    task automatic test_set_get();
        key_t   k;
        value_t v;
        k = fresh_key();
        v = lcg_next();
        run_cmd(cmd_set, k, v, '0, 1'b0);
        run_cmd(cmd_get, k, '0, make_entry(v), 1'b0);
    endtask

    task automatic test_unset();
        key_t   k;
        value_t v;
        k = fresh_key();
        v = lcg_next();
        run_cmd(cmd_set, k, v, '0, 1'b0);
        run_cmd(cmd_unset, k, '0, make_entry(v), 1'b0);
        run_cmd(cmd_get, k, '0, '0, 1'b0);
    endtask

    task automatic test_replace();
        key_t   k;
        value_t v1;
        value_t v2;
        k  = fresh_key();
        v1 = lcg_next();
        v2 = lcg_next();
        run_cmd(cmd_set, k, v1, '0, 1'b0);
        run_cmd(cmd_replace, k, v2, make_entry(v1), 1'b0);
        run_cmd(cmd_get, k, '0, make_entry(v2), 1'b0);
        // Empty key stays empty
        k = fresh_key();
        run_cmd(cmd_replace, k, v1, '0, 1'b0);
        run_cmd(cmd_get, k, '0, '0, 1'b0);
    endtask

    task automatic test_clear_illegal();
        key_t   keys [3];
        value_t v;
        for (int i = 0; i < 3; i++) begin
            keys[i] = fresh_key();
            run_cmd(cmd_set, keys[i], lcg_next(), '0, 1'b0);
        end
        run_cmd(cmd_clear, '0, '0, '0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            run_cmd(cmd_get, keys[i], '0, '0, 1'b0);
        end
        v = lcg_next();
        run_cmd(cmd_set, keys[0], v, '0, 1'b0);
        run_cmd(cmd_t'(3'd6), keys[0], lcg_next(), '0, 1'b1);
        run_cmd(cmd_get, keys[0], '0, make_entry(v), 1'b0);
    endtask

    // Next command waits on the port with req high while the DUT is busy
    task automatic test_random_mix();
        cmd_t   c;
        key_t   k;
        value_t v;
        entry_t old;
        logic   err;
        int     start;
        for (int i = 0; i < 8; i++) begin
            key_pool[i] = rand_key();
        end
        pick_random(c, k, v);
        @(posedge clk);
        // Count from here, the last ack before this edge is settled
        start = ack_count;
        drive_cmd(c, k, v);
        @(negedge clk);
        for (int i = 0; i < 40; i++) begin
            wait_accept();
            model_apply(c, k, v, old, err);
            if (i < 39) begin
                pick_random(c, k, v);
                drive_cmd(c, k, v);
            end else begin
                req <= 1'b0;
            end
            wait_ack();
            check_entry(old);
            check_bit("error", error, err);
        end
        repeat (4) @(negedge clk);
        check_count("ack count", ack_count - start, 40);
    endtask

    initial begin
        rst_n       = 1'b0;
        req         = 1'b0;
        cmd         = cmd_get;
        key         = '0;
        value_in    = '0;
        seed        = 32'h957b;
        cycles      = 0;
        ack_count   = 0;
        cmds_issued = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_set_get();
        test_unset();
        test_replace();
        test_clear_illegal();
        test_random_mix();

        repeat (4) @(negedge clk);
        check_count("ack count", ack_count, cmds_issued);
        $display("Everything OK");
        $finish;
    end

endmodule : tb_kv_store

`default_nettype wire
